// ==== compile.f ====
verilog/owr_pkg.sv
verilog/owr_bit_if.sv
verilog/debouncer.sv
verilog/owr_slot_timer.sv
verilog/owr_byte_shifter.sv
verilog/owr_control.sv
verilog/seg7_display.sv
verilog/owr_system.sv
testbench/owr_assertions.sv
testbench/owr_tb.sv

// ==== Makefile ====
# Verilator build and run of the 1-wire master testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module owr_tb -o owr_sim
	./obj_dir/owr_sim | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/owr_tb.sv ====
/* Testbench for the 1-wire master, with a behavioral slave on each line
   Slave is told when a read is coming, presence answer is random per reset
   Debounce is shortened to 16 cycles, run ends on a cycle limit */

`timescale 1ns/1ps

module owr_tb;

  localparam int n_random    = 12;
  localparam int n_cmds      = n_random + 8;  // Directed commands plus random ones
  localparam int slot_cycles = owr_pkg::t_rst_slot * owr_pkg::tick_cycles;  // Worst case
  localparam int cycle_limit = (n_cmds + 2) * slot_cycles;

  // Standard gfedcba codes, segment on when the bit is 1
  localparam logic [6:0] seg_lut [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  logic               clk;
  logic               rst_n;
  logic               key;
  logic               cmd_valid;
  owr_pkg::owr_op_e   cmd_op;
  logic               cmd_line;
  logic [7:0]         cmd_data;
  logic               busy;
  logic               done;
  logic [7:0]         rsp_data;
  logic               presence;
  logic [1:0]         owr_e;
  logic [1:0]         owr_i = 2'b11;  // Bus idles high
  logic [6:0]         hex0, hex1, hex2, hex3;

  // Slave state per line
  logic [1:0] prev_e = 2'b00;
  int         low_cyc [2]   = '{0, 0};  // Cycles of current low pulse
  int         pull_dly [2]  = '{0, 0};  // Cycles before slave pulls low
  int         pull_len [2]  = '{0, 0};  // Cycles slave holds line low
  int         slot_cnt [2]  = '{0, 0};  // Low pulses seen
  int         rst_ticks [2] = '{0, 0};  // Length of last reset pulse
  logic [7:0] wr_shift [2]  = '{8'h00, 8'h00};  // Decoded bits, LSB first

  // Per-command setup read by the slave
  logic [1:0] pres_choice = 2'b00;
  logic [7:0] slave_byte  = 8'h00;
  logic       rd_mode     = 1'b0;
  int         rd_base     = 0;  // slot_cnt at start of a read

  // Reference model
  logic [7:0] exp_rsp  = 8'h00;
  logic       exp_pres = 1'b0;
  logic       exp_line = 1'b0;

  int errors = 0;
  int checks = 0;
  int tests  = 0;
  int cycles = 0;

  owr_system #(.debounce_cycles(16)) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .key       (key),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_line  (cmd_line),
    .cmd_data  (cmd_data),
    .busy      (busy),
    .done      (done),
    .rsp_data  (rsp_data),
    .presence  (presence),
    .owr_e     (owr_e),
    .owr_i     (owr_i),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 25 MHz stand-in for 24 MHz
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Behavioral slave
  //////////////////////////////////////////////////

  always @(posedge clk) begin : slave
    int   ticks;
    int   idx;
    logic pl;
    for (int l = 0; l < 2; l++) begin
      if (owr_e[l] && !prev_e[l]) begin
        low_cyc[l] = 1;  // Slot start
        idx = slot_cnt[l] - rd_base;
        if (rd_mode && idx >= 0 && idx < 8 && !slave_byte[idx[2:0]]) begin
          pull_dly[l] = 0;
          pull_len[l] = 30 * owr_pkg::tick_cycles;  // Past the sample point
        end
      end else if (owr_e[l]) begin
        low_cyc[l]++;
      end else if (prev_e[l]) begin
        ticks = (low_cyc[l] + owr_pkg::tick_cycles / 2) / owr_pkg::tick_cycles;
        slot_cnt[l]++;
        if (ticks >= 400) begin
          rst_ticks[l] = ticks;
          if (pres_choice[l]) begin
            pull_dly[l] = 30 * owr_pkg::tick_cycles;   // Wait after release
            pull_len[l] = 150 * owr_pkg::tick_cycles;  // Presence pulse
          end
        end else begin
          wr_shift[l] = {ticks < 30, wr_shift[l][7:1]};  // Short low is a 1
        end
      end
      if (pull_dly[l] > 0) begin
        pull_dly[l]--;
        pl = 1'b0;
      end else if (pull_len[l] > 0) begin
        pull_len[l]--;
        pl = 1'b1;
      end else begin
        pl = 1'b0;
      end
      owr_i[l] <= ~(owr_e[l] | pl);  // Wired-AND bus
    end
    prev_e <= owr_e;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [6:0] expect_seg(input logic [3:0] v);
    return ~seg_lut[v];  // Active low
  endfunction

  task automatic compare_value(input string name, input string what, input int exp,
                               input int act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("error %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errs0);
    tests++;
    if (errors == errs0) $display("test %s: ok", name);
    else                 $display("test %s: failed", name);
  endtask

  task automatic inspect_display(input string name);
    compare_value(name, "hex0", int'(expect_seg(exp_rsp[3:0])), int'(hex0));
    compare_value(name, "hex1", int'(expect_seg(exp_rsp[7:4])), int'(hex1));
    compare_value(name, "hex2", int'(expect_seg({3'b000, exp_pres})), int'(hex2));
    compare_value(name, "hex3", int'(expect_seg({3'b000, exp_line})), int'(hex3));
  endtask

  task automatic prepare_slave(input owr_pkg::owr_op_e op, input logic ln);
    pres_choice = 2'($urandom_range(0, 3));
    slave_byte  = 8'($urandom);
    rd_mode     = (op == owr_pkg::op_read_bit) || (op == owr_pkg::op_read_byte);
    rd_base     = slot_cnt[ln];
  endtask

  task automatic wait_done();
    while (done !== 1'b1) @(negedge clk);
  endtask

  // Called at the sample point where done is high
  task automatic score_command(input string name, input owr_pkg::owr_op_e op,
                               input logic ln, input logic [7:0] dat,
                               input int b0, input int b1);
    int n_exp;
    int n_on;
    int n_off;
    n_exp = (op == owr_pkg::op_write_byte || op == owr_pkg::op_read_byte) ? 8 : 1;
    n_on  = ln ? slot_cnt[1] - b1 : slot_cnt[0] - b0;
    n_off = ln ? slot_cnt[0] - b0 : slot_cnt[1] - b1;
    case (op)
      owr_pkg::op_reset: begin
        exp_pres = pres_choice[ln];
        checks++;
        assert (rst_ticks[ln] >= owr_pkg::t_rst_low - 1 &&
                rst_ticks[ln] <= owr_pkg::t_rst_low + 1) else begin
          errors++;
          $display("error %s reset low ticks: expected %0d +-1, actual %0d",
                   name, owr_pkg::t_rst_low, rst_ticks[ln]);
        end
      end
      owr_pkg::op_write_bit:  compare_value(name, "bit", int'(dat[0]), int'(wr_shift[ln][7]));
      owr_pkg::op_write_byte: compare_value(name, "byte", int'(dat), int'(wr_shift[ln]));
      owr_pkg::op_read_bit:   exp_rsp = {7'b0, slave_byte[0]};
      owr_pkg::op_read_byte:  exp_rsp = slave_byte;
      default: ;
    endcase
    exp_line = ln;
    compare_value(name, "slots", n_exp, n_on);
    compare_value(name, "other line slots", 0, n_off);
    compare_value(name, "busy at done", 0, int'(busy));
    compare_value(name, "rsp_data", int'(exp_rsp), int'(rsp_data));
    compare_value(name, "presence", int'(exp_pres), int'(presence));
    @(negedge clk);  // Segments register one cycle after done
    compare_value(name, "done after pulse", 0, int'(done));
    inspect_display(name);
  endtask

  task automatic run_cmd(input string name, input owr_pkg::owr_op_e op, input logic ln,
                         input logic [7:0] dat, input logic intrude);
    int errs0;
    int b0;
    int b1;
    errs0 = errors;
    b0    = slot_cnt[0];
    b1    = slot_cnt[1];
    prepare_slave(op, ln);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_line  <= ln;
    cmd_data  <= dat;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    checks++;
    assert (busy) else begin
      errors++;
      $display("error %s: busy did not rise the cycle after the command", name);
    end
    if (intrude) begin
      repeat (5) @(posedge clk);
      cmd_valid <= 1'b1;  // Must be dropped
      cmd_op    <= owr_pkg::op_read_byte;
      cmd_line  <= ~ln;
      @(posedge clk);
      cmd_valid <= 1'b0;
    end
    wait_done();
    score_command(name, op, ln, dat, b0, b1);
    if (intrude) begin
      repeat (4) @(negedge clk);
      checks++;
      assert (!busy) else begin
        errors++;
        $display("error %s: command given while busy was run afterwards", name);
      end
    end
    report_test(name, errs0);
  endtask

  task automatic key_probe_test();
    int errs0;
    int b0;
    int b1;
    errs0 = errors;
    b0    = slot_cnt[0];
    b1    = slot_cnt[1];
    @(posedge clk);
    key <= 1'b0;  // Bounce shorter than the debounce length
    repeat (10) @(posedge clk);
    key <= 1'b1;
    repeat (40) @(negedge clk);
    checks++;
    assert (!busy && slot_cnt[0] == b0 && slot_cnt[1] == b1) else begin
      errors++;
      $display("error key_bounce: a short bounce started a bus cycle");
    end
    report_test("key_bounce", errs0);

    errs0 = errors;
    prepare_slave(owr_pkg::op_reset, 1'b0);
    pres_choice = 2'b01;  // Device on line 0 answers
    @(posedge clk);
    key <= 1'b0;  // Held press
    wait_done();
    score_command("key_press", owr_pkg::op_reset, 1'b0, 8'h00, b0, b1);
    @(posedge clk);
    key <= 1'b1;
    repeat (40) @(negedge clk);
    checks++;
    assert (!busy) else begin
      errors++;
      $display("error key_press: key release started a bus cycle");
    end
    report_test("key_press", errs0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    owr_pkg::owr_op_e op;
    logic             ln;
    logic [7:0]       dat;
    int               errs0;
    void'($urandom(26766));
    rst_n     = 1'b0;
    key       = 1'b1;  // Released
    cmd_valid = 1'b0;
    cmd_op    = owr_pkg::op_reset;
    cmd_line  = 1'b0;
    cmd_data  = 8'h00;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    errs0 = errors;
    compare_value("after_reset", "busy", 0, int'(busy));
    compare_value("after_reset", "done", 0, int'(done));
    compare_value("after_reset", "owr_e", 0, int'(owr_e));
    inspect_display("after_reset");
    report_test("after_reset", errs0);

    run_cmd("reset_line0", owr_pkg::op_reset, 1'b0, 8'h00, 1'b0);
    run_cmd("reset_line1", owr_pkg::op_reset, 1'b1, 8'h00, 1'b0);
    run_cmd("write_byte", owr_pkg::op_write_byte, 1'b1, 8'($urandom), 1'b0);
    run_cmd("write_bit", owr_pkg::op_write_bit, 1'b0, 8'($urandom), 1'b0);
    run_cmd("read_byte", owr_pkg::op_read_byte, 1'b0, 8'h00, 1'b0);
    run_cmd("read_bit", owr_pkg::op_read_bit, 1'b1, 8'h00, 1'b0);
    run_cmd("busy_ignored", owr_pkg::op_write_byte, 1'b0, 8'($urandom), 1'b1);
    key_probe_test();

    for (int i = 0; i < n_random; i++) begin
      op  = owr_pkg::owr_op_e'(3'($urandom_range(0, 4)));
      ln  = 1'($urandom_range(0, 1));
      dat = 8'($urandom);
      run_cmd($sformatf("random_%0d", i), op, ln, dat, 1'b0);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Simulation PASSED");
    else             $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== testbench/owr_assertions.sv ====
/* Protocol checks on the 1-wire master, bound into the RTL top
   Covers line exclusivity, idle bus and the done/busy relation */

`timescale 1ns/1ps

module owr_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       busy,
  input logic       done,
  input logic [1:0] owr_e,
  input logic       slot_req,
  input logic       slot_done
);

  logic in_flight;  // Slot requested, not yet ended

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)         in_flight <= 1'b0;
    else if (slot_req)  in_flight <= 1'b1;
    else if (slot_done) in_flight <= 1'b0;
  end

  // Never pull both lines at once
  one_line: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(owr_e))
    else $error("owr_e high on both lines");

  // Bus released outside a command
  idle_released: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> owr_e == 2'b00)
    else $error("owr_e high while busy was low");

  // New slot only after the previous one ended
  single_slot: assert property (@(posedge clk) disable iff (!rst_n) slot_req |-> !in_flight)
    else $error("slot requested while another slot was in flight");

  // done ends a busy period, busy falls with it
  done_in_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !busy && $past(busy))
    else $error("done pulsed outside a command");

endmodule

bind owr_system owr_assertions assertions_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .busy      (busy),
  .done      (done),
  .owr_e     (owr_e),
  .slot_req  (bit_if_i.slot_req),
  .slot_done (bit_if_i.slot_done)
);

// ==== verilog/owr_system.sv ====
/* 1-wire master subsystem, tristate pads and pull-ups stay on the board
   owr_e high means pull that line low, there is no strong pull-up output */

`timescale 1ns/1ps

module owr_system #(
  parameter int debounce_cycles = owr_pkg::debounce_default
) (
  input  logic             clk,        // 24 MHz
  input  logic             rst_n,
  input  logic             key,        // Active low button
  input  logic             cmd_valid,
  input  owr_pkg::owr_op_e cmd_op,
  input  logic             cmd_line,
  input  logic [7:0]       cmd_data,
  output logic             busy,
  output logic             done,
  output logic [7:0]       rsp_data,
  output logic             presence,
  output logic [1:0]       owr_e,
  input  logic [1:0]       owr_i,
  output logic [6:0]       hex0,
  output logic [6:0]       hex1,
  output logic [6:0]       hex2,
  output logic [6:0]       hex3
);

  logic       probe;         // Debounced key press
  logic       sh_load;
  logic [7:0] sh_load_data;
  logic       sh_shift;
  logic       sh_in_bit;
  logic       sh_lsb;
  logic       sh_last;
  logic [7:0] sh_data;

  owr_bit_if bit_if_i ();

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  debouncer #(.cn(debounce_cycles)) debouncer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (~key),  // Buttons are active low
    .press (probe)
  );

  owr_control control_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_line     (cmd_line),
    .cmd_data     (cmd_data),
    .probe        (probe),
    .busy         (busy),
    .done         (done),
    .rsp_data     (rsp_data),
    .presence     (presence),
    .bit_if       (bit_if_i.ctrl),
    .sh_load      (sh_load),
    .sh_load_data (sh_load_data),
    .sh_shift     (sh_shift),
    .sh_in_bit    (sh_in_bit),
    .sh_lsb       (sh_lsb),
    .sh_last      (sh_last),
    .sh_data      (sh_data)
  );

  owr_slot_timer slot_timer_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bit_if (bit_if_i.slot),
    .owr_e  (owr_e),
    .owr_i  (owr_i)
  );

  owr_byte_shifter shifter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (sh_load),
    .load_data (sh_load_data),
    .shift     (sh_shift),
    .in_bit    (sh_in_bit),
    .lsb       (sh_lsb),
    .last      (sh_last),
    .data      (sh_data)
  );

  seg7_display display_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .data     (rsp_data),
    .presence (presence),
    .line     (bit_if_i.line),  // Line of the latest command
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3)
  );

endmodule

// ==== verilog/seg7_display.sv ====
/* Four-digit readout, active low segments in gfedcba order
   hex0/hex1 data nibbles, hex2 presence, hex3 line number */

`timescale 1ns/1ps

module seg7_display (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       presence,
  input  logic       line,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3
);

  // Hex digit to inverted segment pattern
  function automatic logic [6:0] hex_seg(input logic [3:0] v);
    logic [6:0] s;
    case (v)
      4'h0: s = 7'h3f;
      4'h1: s = 7'h06;
      4'h2: s = 7'h5b;
      4'h3: s = 7'h4f;
      4'h4: s = 7'h66;
      4'h5: s = 7'h6d;
      4'h6: s = 7'h7d;
      4'h7: s = 7'h07;
      4'h8: s = 7'h7f;
      4'h9: s = 7'h6f;
      4'ha: s = 7'h77;
      4'hb: s = 7'h7c;  // Lower case b
      4'hc: s = 7'h39;
      4'hd: s = 7'h5e;  // Lower case d
      4'he: s = 7'h79;
      default: s = 7'h71;
    endcase
    return ~s;  // Segments light on low
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hex0 <= hex_seg(4'h0);
      hex1 <= hex_seg(4'h0);
      hex2 <= hex_seg(4'h0);
      hex3 <= hex_seg(4'h0);
    end else begin
      hex0 <= hex_seg(data[3:0]);
      hex1 <= hex_seg(data[7:4]);
      hex2 <= hex_seg({3'b000, presence});
      hex3 <= hex_seg({3'b000, line});
    end
  end

endmodule

// ==== verilog/owr_control.sv ====
/* Command FSM for the 1-wire master, commands while busy are dropped
   Probe acts as op_reset on line 0, cmd_valid wins over it
   Only reads update rsp_data, a single read bit lands in bit 0 */

`timescale 1ns/1ps

module owr_control (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cmd_valid,
  input  owr_pkg::owr_op_e cmd_op,
  input  logic             cmd_line,
  input  logic [7:0]       cmd_data,
  input  logic             probe,      // Debounced key press
  output logic             busy,
  output logic             done,       // Pulse, busy falls with it
  output logic [7:0]       rsp_data,
  output logic             presence,
  owr_bit_if.ctrl          bit_if,
  output logic             sh_load,
  output logic [7:0]       sh_load_data,
  output logic             sh_shift,
  output logic             sh_in_bit,
  input  logic             sh_lsb,     // Next bit to write
  input  logic             sh_last,    // Eighth bit in flight
  input  logic [7:0]       sh_data
);

  owr_pkg::owr_state_e state;
  owr_pkg::owr_op_e    op_q;     // Accepted opcode
  owr_pkg::owr_op_e    acc_op;   // Opcode about to be accepted
  logic                accept;
  logic                single;   // One slot only
  logic                rd_op;

  //////////////////////////////////////////////////
  // Arbitration and decode
  //////////////////////////////////////////////////

  assign accept = (state == owr_pkg::idle) && (cmd_valid || probe);
  assign acc_op = cmd_valid ? cmd_op : owr_pkg::op_reset;  // Command wins

  assign single = (op_q == owr_pkg::op_write_bit) || (op_q == owr_pkg::op_read_bit);
  assign rd_op  = (op_q == owr_pkg::op_read_bit)  || (op_q == owr_pkg::op_read_byte);

  // Shifter controls
  assign sh_load      = accept && (acc_op != owr_pkg::op_reset);
  assign sh_load_data = cmd_data;  // Read data overwrites it anyway
  assign sh_shift     = (state == owr_pkg::bit_wait) && bit_if.slot_done;
  assign sh_in_bit    = bit_if.sample;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= owr_pkg::idle;
      op_q             <= owr_pkg::op_reset;
      bit_if.line      <= 1'b0;
      bit_if.slot_req  <= 1'b0;
      bit_if.slot_kind <= owr_pkg::slot_reset;
      busy             <= 1'b0;
      done             <= 1'b0;
      rsp_data         <= 8'h00;
      presence         <= 1'b0;
    end else begin
      bit_if.slot_req <= 1'b0;  // Strobes
      done            <= 1'b0;
      case (state)
        owr_pkg::idle: begin
          if (accept) begin
            op_q        <= acc_op;
            bit_if.line <= cmd_valid ? cmd_line : 1'b0;  // Probe uses line 0
            busy        <= 1'b1;
            if (acc_op == owr_pkg::op_reset) begin
              bit_if.slot_req  <= 1'b1;
              bit_if.slot_kind <= owr_pkg::slot_reset;
              state            <= owr_pkg::reset_wait;
            end else begin
              state <= owr_pkg::byte_next;  // Wait for shifter load
            end
          end
        end
        owr_pkg::reset_wait: begin
          if (bit_if.slot_done) state <= owr_pkg::finish;
        end
        owr_pkg::byte_next: begin
          bit_if.slot_req <= 1'b1;
          if (rd_op)       bit_if.slot_kind <= owr_pkg::slot_read;
          else if (sh_lsb) bit_if.slot_kind <= owr_pkg::slot_write1;
          else             bit_if.slot_kind <= owr_pkg::slot_write0;
          state <= owr_pkg::bit_wait;
        end
        owr_pkg::bit_wait: begin
          if (bit_if.slot_done) begin
            state <= (single || sh_last) ? owr_pkg::finish : owr_pkg::byte_next;
          end
        end
        owr_pkg::finish: begin
          busy  <= 1'b0;
          done  <= 1'b1;
          state <= owr_pkg::idle;
          if (op_q == owr_pkg::op_reset)     presence <= bit_if.sample;
          if (op_q == owr_pkg::op_read_bit)  rsp_data <= {7'b0, sh_data[7]};  // Entered at MSB
          if (op_q == owr_pkg::op_read_byte) rsp_data <= sh_data;
        end
        default: state <= owr_pkg::idle;
      endcase
    end
  end

endmodule

// ==== verilog/owr_byte_shifter.sv ====
/* LSB-first byte shift register, new bits enter at bit 7
   last flags the eighth shift since the most recent load */

`timescale 1ns/1ps

module owr_byte_shifter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [7:0] load_data,
  input  logic       shift,
  input  logic       in_bit,
  output logic       lsb,
  output logic       last,
  output logic [7:0] data
);

  logic [2:0] cnt;  // Bits shifted since load

  // Payload
  always_ff @(posedge clk) begin
    if (load)       data <= load_data;
    else if (shift) data <= {in_bit, data[7:1]};  // Right shift, LSB goes out first
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= 3'd0;
    end else if (load) begin
      cnt <= 3'd0;
    end else if (shift) begin
      cnt <= cnt + 1'b1;  // Wraps after eight
    end
  end

  assign lsb  = data[0];
  assign last = (cnt == 3'd7);  // Shift in flight is the eighth

endmodule

// ==== verilog/owr_slot_timer.sv ====
/* Bit-slot engine for two 1-wire lines, only the selected line is driven
   Prescaler is free-running, so slot edges move by up to one tick */

`timescale 1ns/1ps

module owr_slot_timer (
  input  logic       clk,
  input  logic       rst_n,
  owr_bit_if.slot    bit_if,
  output logic [1:0] owr_e,  // Pull-down enable per line
  input  logic [1:0] owr_i   // Line level from pad
);

  owr_pkg::pre_t      pre;        // Prescaler
  logic               tick;       // One per microsecond
  logic [1:0]         owr_i_s1;   // Line synchronizer
  logic [1:0]         owr_i_s2;
  logic               line_in;    // Selected line, synchronized
  logic               active;     // Slot in progress
  owr_pkg::owr_slot_e kind_q;
  logic               line_q;
  owr_pkg::tick_t     t_cnt;      // Ticks since slot start
  owr_pkg::tick_t     low_t;      // Ticks with line pulled low
  owr_pkg::tick_t     samp_t;     // Sample point
  owr_pkg::tick_t     last_t;     // Final tick of slot

  //////////////////////////////////////////////////
  // Microsecond prescaler
  //////////////////////////////////////////////////

  assign tick = (pre == owr_pkg::pre_t'(owr_pkg::tick_cycles - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pre <= '0;
    else        pre <= tick ? '0 : pre + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owr_i_s1 <= 2'b11;  // Idle bus is pulled high
      owr_i_s2 <= 2'b11;
    end else begin
      owr_i_s1 <= owr_i;
      owr_i_s2 <= owr_i_s1;
    end
  end

  assign line_in = owr_i_s2[line_q];

  //////////////////////////////////////////////////
  // Slot timing
  //////////////////////////////////////////////////

  always_comb begin
    case (kind_q)
      owr_pkg::slot_reset:  low_t = owr_pkg::tick_t'(owr_pkg::t_rst_low);
      owr_pkg::slot_write0: low_t = owr_pkg::tick_t'(owr_pkg::t_w0_low);
      default:              low_t = owr_pkg::tick_t'(owr_pkg::t_w1_low);  // Write 1, read
    endcase
    if (kind_q == owr_pkg::slot_reset) begin
      samp_t = owr_pkg::tick_t'(owr_pkg::t_rst_sample);
      last_t = owr_pkg::tick_t'(owr_pkg::t_rst_slot - 1);
    end else begin
      samp_t = owr_pkg::tick_t'(owr_pkg::t_rd_sample);  // Write slots read back too
      last_t = owr_pkg::tick_t'(owr_pkg::t_slot - 1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active           <= 1'b0;
      kind_q           <= owr_pkg::slot_reset;
      line_q           <= 1'b0;
      t_cnt            <= '0;
      bit_if.slot_done <= 1'b0;
      bit_if.sample    <= 1'b0;
    end else begin
      bit_if.slot_done <= 1'b0;
      if (bit_if.slot_req) begin
        active <= 1'b1;
        kind_q <= bit_if.slot_kind;
        line_q <= bit_if.line;
        t_cnt  <= '0;
      end else if (active && tick) begin
        t_cnt <= t_cnt + 1'b1;
        if (t_cnt == samp_t) begin
          // Presence is the slave pulling the line low
          bit_if.sample <= (kind_q == owr_pkg::slot_reset) ? ~line_in : line_in;
        end
        if (t_cnt == last_t) begin
          active           <= 1'b0;
          bit_if.slot_done <= 1'b1;
        end
      end
    end
  end

  // Pull down only the selected line during the low phase
  assign owr_e = (active && (t_cnt < low_t)) ? (line_q ? 2'b10 : 2'b01) : 2'b00;

endmodule

// ==== verilog/debouncer.sv ====
/* Button debouncer with a one-cycle press pulse on an accepted rising edge
   Input is asynchronous and synchronized here, cn must be at least 1 */

`timescale 1ns/1ps

module debouncer #(
  parameter int cn = owr_pkg::debounce_default  // Stable cycles to accept a change
) (
  input  logic clk,
  input  logic rst_n,
  input  logic d,      // Active high
  output logic press   // One-cycle pulse
);

  typedef logic [$clog2(cn+1)-1:0] cnt_t;

  logic d_s1, d_s2;  // Synchronizer
  logic stable;      // Accepted level
  cnt_t cnt;         // Cycles spent differing from stable

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_s1 <= 1'b0;
      d_s2 <= 1'b0;
    end else begin
      d_s1 <= d;
      d_s2 <= d_s1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stable <= 1'b0;  // Released
      cnt    <= '0;
      press  <= 1'b0;
    end else begin
      press <= 1'b0;
      if (d_s2 == stable) begin
        cnt <= '0;  // Bounce back, start over
      end else if (cnt == cnt_t'(cn - 1)) begin
        stable <= d_s2;  // Held long enough
        cnt    <= '0;
        press  <= d_s2;  // Rising edges only
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/owr_bit_if.sv ====
/* Slot request link between the command FSM and the bit-slot engine
   A new slot_req is only legal after slot_done of the previous slot */

`timescale 1ns/1ps

interface owr_bit_if;

  // Request side
  logic                slot_req;   // One-cycle strobe
  owr_pkg::owr_slot_e  slot_kind;  // Reset, write0, write1 or read
  logic                line;       // Target line 0 or 1

  // Response side
  logic                slot_done;  // One-cycle pulse at end of slot
  logic                sample;     // Line value, or presence after reset slot

  //////////////////////////////////////////////////
  // Modports
  //////////////////////////////////////////////////

  modport ctrl (
    output slot_req,
    output slot_kind,
    output line,
    input  slot_done,
    input  sample
  );

  modport slot (
    input  slot_req,
    input  slot_kind,
    input  line,
    output slot_done,
    output sample
  );

endinterface

// ==== verilog/owr_pkg.sv ====
/* Shared timing and types for the 1-wire master
   Timing assumes a 24 MHz clock, so one tick is one microsecond */

package owr_pkg;

  //////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////

  localparam int tick_cycles = 24;  // Clock cycles per microsecond tick

  // Reset/presence slot, in ticks
  localparam int t_rst_low    = 480;  // Master holds line low
  localparam int t_rst_sample = 550;  // Presence sample point
  localparam int t_rst_slot   = 960;  // End of reset slot

  // Data slots, in ticks
  localparam int t_w0_low    = 60;  // Write 0 low time
  localparam int t_w1_low    = 6;   // Write 1 and read low time
  localparam int t_rd_sample = 15;  // Read sample point
  localparam int t_slot      = 70;  // End of data slot

  localparam int debounce_default = 240000;  // 10 ms at 24 MHz

  // Counter widths derived from the timing above
  localparam int pre_w  = $clog2(tick_cycles);
  localparam int tick_w = $clog2(t_rst_slot + 1);

  typedef logic [pre_w-1:0]  pre_t;   // Prescaler count
  typedef logic [tick_w-1:0] tick_t;  // Ticks within one slot

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    op_reset,       // Reset pulse, presence probe
    op_write_bit,
    op_read_bit,
    op_write_byte,  // LSB first
    op_read_byte    // LSB first
  } owr_op_e;

  typedef enum logic [1:0] {
    slot_reset,
    slot_write0,
    slot_write1,
    slot_read
  } owr_slot_e;

  typedef enum logic [2:0] {
    idle,
    reset_wait,  // Reset slot in flight
    bit_wait,    // Data slot in flight
    byte_next,   // Issue next data slot
    finish       // Publish result
  } owr_state_e;

endpackage
